// ==== bus_ctrl_pkg.sv ====
/*
 * Shared settings and readback address maps, bus structs and version constants
 * for the control and status block. Modules import it inside their bodies.
 */
`default_nettype none

package bus_ctrl_pkg;

   // --------------------------------------------------
   // Settings bus address map
   // --------------------------------------------------
   typedef enum logic [7:0] {
      SR_LEDS       = 8'd0,
      SR_SW_RST     = 8'd1,
      SR_CLOCK_CTRL = 8'd2,
      SR_SFPP_CTRL0 = 8'd8,
      SR_SFPP_CTRL1 = 8'd9
   } sr_addr_e;

   // --------------------------------------------------
   // Readback address map
   // --------------------------------------------------
   typedef enum logic [7:0] {
      RB_COUNTER      = 8'd0,
      RB_CLK_STATUS   = 8'd3,
      RB_ETH_TYPE0    = 8'd4,
      RB_ETH_TYPE1    = 8'd5,
      RB_COMPAT_NUM   = 8'd6,
      RB_SFPP_STATUS0 = 8'd8,
      RB_SFPP_STATUS1 = 8'd9
   } rb_addr_e;

   // One settings write, address on top
   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] data;
   } set_req_t;

   // Cage pins, same order as the status word
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfpp_pins_t;

   // Per-cage status word as seen on readback
   typedef struct packed {
      logic [15:0] phy_status;
      logic [9:0]  zero;
      sfpp_pins_t  changed;
      sfpp_pins_t  pins;
   } sfpp_status_t;

   // Compatibility number, major in the upper half
   localparam logic [15:0] COMPAT_MAJOR = 16'h000B;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   localparam int RB_DATA_W = 32;

endpackage

`default_nettype wire

// ==== bus_ctrl_tb_table.svh ====
/*
 * Operation table for the control block testbench, loaded before the run.
 * Write rows get their data and expected values drawn at load time.
 */
`ifndef BUS_CTRL_TB_TABLE_SVH
`define BUS_CTRL_TB_TABLE_SVH

// Columns: op, address, data, expected word
//   OP_READ  data bit 0 keeps the strobe up into the next row
//   OP_PINS  address is the cage, data is {phy_status, pins}
//   OP_WAIT  data is the idle cycle count
task automatic load_table();
   add_row(OP_READ,  RB_COMPAT_NUM,   32'd0, 32'h000B_0000);
   // One write per register, then two unmapped addresses
   add_row(OP_WRITE, SR_LEDS,         32'd0, 32'd0);
   add_row(OP_WRITE, SR_SW_RST,       32'd0, 32'd0);
   add_row(OP_WRITE, SR_CLOCK_CTRL,   32'd0, 32'd0);
   add_row(OP_WRITE, SR_SFPP_CTRL0,   32'd0, 32'd0);
   add_row(OP_WRITE, SR_SFPP_CTRL1,   32'd0, 32'd0);
   add_row(OP_WRITE, 8'd5,            32'd0, 32'd0);
   add_row(OP_WRITE, 8'd255,          32'd0, 32'd0);
   add_row(OP_READ,  RB_ETH_TYPE0,    32'd0, 32'd1);
   add_row(OP_READ,  RB_ETH_TYPE1,    32'd0, 32'd0);
   add_row(OP_READ,  RB_CLK_STATUS,   32'd0, 32'h0000_005A);
   add_row(OP_READ,  8'd7,            32'd0, 32'd0);
   // Counter step over a known gap
   add_row(OP_READ,  RB_COUNTER,      32'd0, 32'd0);
   add_row(OP_WAIT,  8'd0,            32'd13, 32'd0);
   add_row(OP_READ,  RB_COUNTER,      32'd0, 32'd0);
   // Cage 0 pins and PHY bits, read twice, then the quiet cage
   add_row(OP_PINS,  8'd0,            {13'b0, 16'hBEEF, 3'b101}, 32'd0);
   add_row(OP_WAIT,  8'd0,            32'd6, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS0, 32'd0, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS0, 32'd0, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS1, 32'd0, 32'd0);
   add_row(OP_PINS,  8'd1,            {13'b0, 16'h0F01, 3'b010}, 32'd0);
   add_row(OP_WAIT,  8'd0,            32'd8, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS1, 32'd0, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS0, 32'd0, 32'd0);
   // Back-to-back burst
   add_row(OP_READ,  RB_COMPAT_NUM,   32'd1, 32'h000B_0000);
   add_row(OP_READ,  RB_ETH_TYPE0,    32'd1, 32'd1);
   add_row(OP_READ,  RB_COUNTER,      32'd1, 32'd0);
   add_row(OP_READ,  RB_SFPP_STATUS1, 32'd1, 32'd0);
   add_row(OP_READ,  8'd2,            32'd0, 32'd0);
   add_row(OP_WRITE, SR_LEDS,         32'd0, 32'd0);
endtask

`endif

// ==== bus_ctrl_tb.sv ====
/*
 * Testbench for the control and status block. Runs the operation table and
 * checks register outputs and readback responses against a reference model.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl_tb;

   import bus_ctrl_pkg::*;

   localparam logic [7:0] CLK_STATUS_VAL = 8'h5A;

   typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PINS, OP_WAIT} op_e;
   typedef enum logic [1:0] {RSP_WORD, RSP_STATUS, RSP_COUNT} rsp_e;

   typedef struct packed {
      op_e         op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
   } row_t;

   // One outstanding read with the tb cycle of its strobe
   typedef struct packed {
      rsp_e        kind;
      logic [31:0] exp;
      logic [31:0] cycle;
   } rsp_exp_t;

   typedef struct packed {
      logic [7:0]      leds;
      logic [3:0]      sw_rst;
      logic [6:0]      clock_control;
      logic [1:0][1:0] sfpp_rs;
   } regs_t;

   logic                    clk = 1'b0;
   logic                    i_rst_n;
   logic                    i_set_stb;
   set_req_t                i_set;
   logic                    i_rb_rd_stb;
   rb_addr_e                i_rb_addr;
   sfpp_pins_t [1:0]        i_sfpp_pins;
   logic [1:0][15:0]        i_phy_status;
   logic [7:0]              i_clock_status;
   logic [7:0]              o_leds;
   logic [3:0]              o_sw_rst;
   logic [6:0]              o_clock_control;
   logic [1:0][1:0]         o_sfpp_rs;
   logic                    o_rb_valid;
   logic [RB_DATA_W-1:0]    o_rb_data;
   logic [1:0]              o_sfpp_clear;

   // Reference model
   regs_t                   exp_regs;
   sfpp_pins_t [1:0]        pin_model;
   sfpp_pins_t [1:0]        chg_model;
   logic [1:0][15:0]        phy_model;
   // Expected per-cage clear pulse, follows the read strobe
   logic [1:0]              exp_clear;

   row_t                    rows[$];
   rsp_exp_t                rsp_q[$];
   int                      value_errs = 0;
   int                      proto_errs = 0;
   int                      cycles = 0;
   int                      cycle_limit = 0;
   logic                    mon_en = 1'b0;
   logic                    pend = 1'b0;
   logic                    have_cnt = 1'b0;
   logic [31:0]             prev_cnt_val;
   logic [31:0]             prev_cnt_cycle;

   // 20 ns period
   always #10 clk = ~clk;

   bus_ctrl_top #(
      .CLK_CTRL_RESET (7'b1000000),
      .ETH_TYPE0      (1'b1),
      .ETH_TYPE1      (1'b0)
   ) bus_ctrl_top_inst (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_set_stb       (i_set_stb),
      .i_set           (i_set),
      .i_rb_rd_stb     (i_rb_rd_stb),
      .i_rb_addr       (i_rb_addr),
      .i_sfpp_pins     (i_sfpp_pins),
      .i_phy_status    (i_phy_status),
      .i_clock_status  (i_clock_status),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp_rs       (o_sfpp_rs),
      .o_rb_valid      (o_rb_valid),
      .o_rb_data       (o_rb_data),
      .o_sfpp_clear    (o_sfpp_clear)
   );

   // --------------------------------------------------
   // Table and compare helpers
   // --------------------------------------------------
   task automatic add_row(input op_e op, input logic [7:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
      rows.push_back({op, addr, data, exp});
   endtask

   `include "bus_ctrl_tb_table.svh"

   // Register widths from the address map
   function automatic logic [31:0] field_mask(input logic [7:0] addr);
      case (addr)
         SR_LEDS:       return 32'h0000_00FF;
         SR_SW_RST:     return 32'h0000_000F;
         SR_CLOCK_CTRL: return 32'h0000_007F;
         SR_SFPP_CTRL0: return 32'h0000_0003;
         SR_SFPP_CTRL1: return 32'h0000_0003;
         default:       return 32'h0;
      endcase
   endfunction

   // Status word the model predicts for one cage
   function automatic sfpp_status_t status_word(input logic cage);
      sfpp_status_t s;
      s.phy_status = phy_model[cage];
      s.zero       = '0;
      s.changed    = chg_model[cage];
      s.pins       = pin_model[cage];
      return s;
   endfunction

   task automatic note_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      value_errs++;
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
   endtask

   task automatic check_word(input string name, input logic [RB_DATA_W-1:0] exp,
                             input logic [RB_DATA_W-1:0] act);
      if (act !== exp) note_mismatch(name, exp, act);
   endtask

   task automatic check_status(input sfpp_status_t exp, input sfpp_status_t act);
      string exp_s;
      string act_s;
      if (act !== exp) begin
         value_errs++;
         exp_s = $sformatf("phy %h chg %b pins %b zero %h",
                           exp.phy_status, exp.changed, exp.pins, exp.zero);
         act_s = $sformatf("phy %h chg %b pins %b zero %h",
                           act.phy_status, act.changed, act.pins, act.zero);
         $display("** Error at %0t: o_rb_data status expected %s got %s",
                  $time, exp_s, act_s);
      end
   endtask

   task automatic check_clear(input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) note_mismatch("o_sfpp_clear", 32'(exp), 32'(act));
   endtask

   task automatic check_regs(input regs_t exp);
      if (o_leds !== exp.leds)
         note_mismatch("o_leds", 32'(exp.leds), 32'(o_leds));
      if (o_sw_rst !== exp.sw_rst)
         note_mismatch("o_sw_rst", 32'(exp.sw_rst), 32'(o_sw_rst));
      if (o_clock_control !== exp.clock_control)
         note_mismatch("o_clock_control", 32'(exp.clock_control), 32'(o_clock_control));
      if (o_sfpp_rs !== exp.sfpp_rs)
         note_mismatch("o_sfpp_rs", 32'(exp.sfpp_rs), 32'(o_sfpp_rs));
   endtask

   // --------------------------------------------------
   // Row drivers
   // --------------------------------------------------
   task automatic apply_write(input row_t r);
      i_set_stb <= 1'b1;
      i_set     <= {r.addr, r.data};
      // Old values must hold until the edge that takes the strobe
      @(negedge clk);
      check_regs(exp_regs);
      case (r.addr)
         SR_LEDS:       exp_regs.leds          = r.exp[7:0];
         SR_SW_RST:     exp_regs.sw_rst        = r.exp[3:0];
         SR_CLOCK_CTRL: exp_regs.clock_control = r.exp[6:0];
         SR_SFPP_CTRL0: exp_regs.sfpp_rs[0]    = r.exp[1:0];
         SR_SFPP_CTRL1: exp_regs.sfpp_rs[1]    = r.exp[1:0];
         default:       exp_regs = exp_regs;
      endcase
      @(posedge clk);
      i_set_stb <= 1'b0;
      @(negedge clk);
      check_regs(exp_regs);
   endtask

   task automatic wait_responses();
      while (rsp_q.size() != 0) @(negedge clk);
   endtask

   task automatic issue_read(input row_t r);
      rsp_exp_t   e;
      logic       cage;
      logic [1:0] clr;
      cage        = (r.addr == RB_SFPP_STATUS1);
      clr         = '0;
      e.cycle     = cycles;
      e.exp       = r.exp;
      e.kind      = RSP_WORD;
      i_rb_rd_stb <= 1'b1;
      i_rb_addr   <= rb_addr_e'(r.addr);
      if (r.addr == RB_COUNTER) begin
         e.kind = RSP_COUNT;
      end else if (r.addr == RB_SFPP_STATUS0 || r.addr == RB_SFPP_STATUS1) begin
         // Response shows the flags before the read clears them
         e.kind          = RSP_STATUS;
         e.exp           = status_word(cage);
         chg_model[cage] = '0;
         clr[cage]       = 1'b1;
      end
      exp_clear <= clr;
      rsp_q.push_back(e);
      // Data bit 0 keeps the strobe up for a burst
      if (!r.data[0]) begin
         @(posedge clk);
         i_rb_rd_stb <= 1'b0;
         exp_clear   <= '0;
         wait_responses();
      end
   endtask

   // New pins mark the changed ones in the model
   task automatic drive_pins(input row_t r);
      logic cage;
      cage            = r.addr[0];
      chg_model[cage] = chg_model[cage] | (pin_model[cage] ^ r.data[2:0]);
      pin_model[cage] = r.data[2:0];
      phy_model[cage] = r.data[18:3];
      i_sfpp_pins[cage]  <= r.data[2:0];
      i_phy_status[cage] <= r.data[18:3];
   endtask

   // --------------------------------------------------
   // Response monitor on the falling edge
   // --------------------------------------------------
   always @(negedge clk) begin
      rsp_exp_t e;
      if (mon_en) begin
         // Clear pulse only while a status strobe is up
         check_clear(exp_clear, o_sfpp_clear);
         if (pend && !o_rb_valid) begin
            proto_errs++;
            $display("Read response missing one cycle after its strobe at %0t", $time);
            if (rsp_q.size() != 0) e = rsp_q.pop_front();
         end else if (o_rb_valid && (!pend || rsp_q.size() == 0)) begin
            proto_errs++;
            $display("Read response at %0t without a matching strobe", $time);
         end else if (o_rb_valid) begin
            e = rsp_q.pop_front();
            case (e.kind)
               RSP_STATUS: check_status(e.exp, o_rb_data);
               RSP_COUNT: begin
                  // Counter step equals the cycles between the two strobes
                  if (have_cnt) begin
                     check_word("o_rb_data counter", prev_cnt_val + (e.cycle - prev_cnt_cycle),
                                o_rb_data);
                  end
                  have_cnt       = 1'b1;
                  prev_cnt_val   = o_rb_data;
                  prev_cnt_cycle = e.cycle;
               end
               default: check_word("o_rb_data", e.exp, o_rb_data);
            endcase
         end
         // Strobe seen now expects its response next cycle
         pend = i_rb_rd_stb;
      end
   end

   // Cycle count and run limit
   always @(negedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, %0d reads outstanding", cycles, rsp_q.size());
         $display("Checks failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      row_t r;
      i_rst_n        = 1'b0;
      i_set_stb      = 1'b0;
      i_set          = '0;
      i_rb_rd_stb    = 1'b0;
      i_rb_addr      = RB_COUNTER;
      i_sfpp_pins    = '0;
      i_phy_status   = '0;
      i_clock_status = CLK_STATUS_VAL;
      exp_regs       = '{leds: 8'h0, sw_rst: 4'h0, clock_control: 7'b1000000, sfpp_rs: '0};
      pin_model      = '0;
      chg_model      = '0;
      phy_model      = '0;
      exp_clear      = '0;
      void'($urandom(32'h5e0327b0));
      load_table();
      // Write data and masked expected values from the same draw
      foreach (rows[i]) begin
         r = rows[i];
         if (r.op == OP_WRITE) begin
            r.data  = $urandom;
            r.exp   = r.data & field_mask(r.addr);
            rows[i] = r;
         end
      end
      cycle_limit = rows.size() * 16 + 100;

      repeat (8) @(posedge clk);
      i_rst_n <= 1'b1;
      @(negedge clk);
      check_regs(exp_regs);
      mon_en = 1'b1;

      foreach (rows[i]) begin
         r = rows[i];
         @(posedge clk);
         // Strobes drop unless the row raises them again
         i_set_stb   <= 1'b0;
         i_rb_rd_stb <= 1'b0;
         exp_clear   <= '0;
         case (r.op)
            OP_WRITE: apply_write(r);
            OP_READ:  issue_read(r);
            OP_PINS:  drive_pins(r);
            default:  repeat (r.data) @(posedge clk);
         endcase
      end
      @(posedge clk);
      i_rb_rd_stb <= 1'b0;
      exp_clear   <= '0;
      wait_responses();
      repeat (2) @(negedge clk);

      $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bus_ctrl_top.sv ====
/*
 * Control and status block top level. Connects the settings register bank,
 * one status monitor per SFP+ cage and the readback port.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl_top #(
   parameter logic [6:0] CLK_CTRL_RESET = 7'b1000000,
   parameter bit         ETH_TYPE0      = 1'b0,
   parameter bit         ETH_TYPE1      = 1'b0
) (
   input  wire                                 clk,
   input  wire                                 i_rst_n,
   // Settings bus
   input  logic                                i_set_stb,
   input  bus_ctrl_pkg::set_req_t              i_set,
   // Readback bus
   input  logic                                i_rb_rd_stb,
   input  bus_ctrl_pkg::rb_addr_e              i_rb_addr,
   // Cage and clocking status inputs
   input  bus_ctrl_pkg::sfpp_pins_t [1:0]      i_sfpp_pins,
   input  wire  [1:0][15:0]                    i_phy_status,
   input  wire  [7:0]                          i_clock_status,
   // Register outputs
   output logic [7:0]                          o_leds,
   output logic [3:0]                          o_sw_rst,
   output logic [6:0]                          o_clock_control,
   output logic [1:0][1:0]                     o_sfpp_rs,
   // Readback response
   output logic                                o_rb_valid,
   output logic [bus_ctrl_pkg::RB_DATA_W-1:0]  o_rb_data,
   output logic [1:0]                          o_sfpp_clear
);

   import bus_ctrl_pkg::*;

   sfpp_status_t [1:0] sfpp_status;

   // --------------------------------------------------
   // Settings registers
   // --------------------------------------------------
   ctrl_regs #(
      .CLK_CTRL_RESET (CLK_CTRL_RESET)
   ) ctrl_regs_inst (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_set_stb       (i_set_stb),
      .i_set           (i_set),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_sfpp_rs       (o_sfpp_rs)
   );

   // --------------------------------------------------
   // Per-cage status monitors
   // --------------------------------------------------
   for (genvar cage = 0; cage < 2; cage++) begin : g_sfpp_mon
      sfpp_status_monitor sfpp_status_monitor_inst (
         .clk          (clk),
         .i_rst_n      (i_rst_n),
         .i_pins       (i_sfpp_pins[cage]),
         .i_phy_status (i_phy_status[cage]),
         .i_clear      (o_sfpp_clear[cage]),
         .o_status     (sfpp_status[cage])
      );
   end

   // Readback port, also source of the status clears
   readback_mux #(
      .ETH_TYPE0 (ETH_TYPE0),
      .ETH_TYPE1 (ETH_TYPE1)
   ) readback_mux_inst (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .i_rb_addr      (i_rb_addr),
      .i_clock_status (i_clock_status),
      .i_sfpp_status  (sfpp_status),
      .o_rb_valid     (o_rb_valid),
      .o_rb_data      (o_rb_data),
      .o_sfpp_clear   (o_sfpp_clear)
   );

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
bus_ctrl_pkg.sv
ctrl_regs.sv
sfpp_status_monitor.sv
readback_mux.sv
bus_ctrl_top.sv
bus_ctrl_tb.sv

// ==== ctrl_regs.sv ====
/*
 * Settings-bus register bank. Each strobed write loads the register at the
 * matching address; outputs update one cycle after the strobe.
 */
`timescale 1ns/10ps
`default_nettype none

module ctrl_regs #(
   parameter logic [6:0] CLK_CTRL_RESET = 7'b1000000
) (
   input  wire                     clk,
   input  wire                     i_rst_n,
   input  logic                    i_set_stb,
   input  bus_ctrl_pkg::set_req_t  i_set,
   output logic [7:0]              o_leds,
   output logic [3:0]              o_sw_rst,
   output logic [6:0]              o_clock_control,
   output logic [1:0][1:0]         o_sfpp_rs
);

   import bus_ctrl_pkg::*;

   // --------------------------------------------------
   // Write decode
   // --------------------------------------------------
   // SW_RST bits
   //   [0] PHY reset
   //   [1] radio clock domain reset
   //   [2] radio clock PLL reset
   //   [3] spare
   // SFPP_CTRLn bits, 1 = pull rate-select pin low
   //   [0] RS0
   //   [1] RS1
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         // Bit 6 keeps the GPSDO enabled out of reset
         o_clock_control <= CLK_CTRL_RESET;
         o_sfpp_rs       <= '0;
      end else if (i_set_stb) begin
         case (i_set.addr)
            SR_LEDS: begin
               o_leds <= i_set.data[7:0];
            end
            SR_SW_RST: begin
               o_sw_rst <= i_set.data[3:0];
            end
            SR_CLOCK_CTRL: begin
               o_clock_control <= i_set.data[6:0];
            end
            SR_SFPP_CTRL0: begin
               o_sfpp_rs[0] <= i_set.data[1:0];
            end
            SR_SFPP_CTRL1: begin
               o_sfpp_rs[1] <= i_set.data[1:0];
            end
            default: begin
               // Unmapped address, bank unchanged
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== readback_mux.sv ====
/*
 * Readback port. Registers the addressed word one cycle after each read strobe,
 * keeps the free-running cycle counter and issues the per-cage status clears.
 */
`timescale 1ns/10ps
`default_nettype none

module readback_mux #(
   parameter bit ETH_TYPE0 = 1'b0,
   parameter bit ETH_TYPE1 = 1'b0
) (
   input  wire                                   clk,
   input  wire                                   i_rst_n,
   input  logic                                  i_rb_rd_stb,
   input  bus_ctrl_pkg::rb_addr_e                i_rb_addr,
   input  wire  [7:0]                            i_clock_status,
   input  bus_ctrl_pkg::sfpp_status_t [1:0]      i_sfpp_status,
   output logic                                  o_rb_valid,
   output logic [bus_ctrl_pkg::RB_DATA_W-1:0]    o_rb_data,
   output logic [1:0]                            o_sfpp_clear
);

   import bus_ctrl_pkg::*;

   logic [RB_DATA_W-1:0] counter_q;
   logic [RB_DATA_W-1:0] rb_sel;

   // --------------------------------------------------
   // Free-running cycle counter
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         counter_q <= '0;
      end else begin
         counter_q <= counter_q + 1'b1;
      end
   end

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         RB_COUNTER:      rb_sel = counter_q;
         RB_CLK_STATUS:   rb_sel = {24'b0, i_clock_status};
         // 1 = 10G port, 0 = 1G port
         RB_ETH_TYPE0:    rb_sel = RB_DATA_W'(ETH_TYPE0);
         RB_ETH_TYPE1:    rb_sel = RB_DATA_W'(ETH_TYPE1);
         RB_COMPAT_NUM:   rb_sel = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_SFPP_STATUS0: rb_sel = i_sfpp_status[0];
         RB_SFPP_STATUS1: rb_sel = i_sfpp_status[1];
         default:         rb_sel = '0;
      endcase
   end

   // Reading a status word clears its change flags on the same edge,
   // while the response register still samples the old flags
   assign o_sfpp_clear[0] = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS0);
   assign o_sfpp_clear[1] = i_rb_rd_stb && (i_rb_addr == RB_SFPP_STATUS1);

   // --------------------------------------------------
   // Response register
   // --------------------------------------------------
   // One response per strobe, exactly one cycle later
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= i_rb_rd_stb;
      end
   end

   // Payload only loads on a strobe
   always_ff @(posedge clk) begin
      if (i_rb_rd_stb) begin
         o_rb_data <= rb_sel;
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the control block testbench
# Exit status is nonzero when the log reports a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module bus_ctrl_tb \
   -o bus_ctrl_sim > build.log 2>&1 \
   && ./obj_dir/bus_ctrl_sim > sim.log 2>&1 \
   || { cat build.log; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// ==== sfpp_status_monitor.sv ====
/*
 * Status monitor for one SFP+ cage. Brings the cage pins and PHY status into
 * the bus clock domain and latches a sticky change flag per pin until cleared.
 */
`timescale 1ns/10ps
`default_nettype none

module sfpp_status_monitor (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  bus_ctrl_pkg::sfpp_pins_t   i_pins,
   input  wire  [15:0]                i_phy_status,
   input  logic                       i_clear,
   output bus_ctrl_pkg::sfpp_status_t o_status
);

   import bus_ctrl_pkg::*;

   localparam int PIN_W  = $bits(sfpp_pins_t);
   localparam int SYNC_W = PIN_W + 16;

   // PHY bits on top, cage pins at the bottom
   logic [SYNC_W-1:0] raw_in;
   logic [SYNC_W-1:0] meta_q;
   logic [SYNC_W-1:0] sync_q;
   logic [PIN_W-1:0]  prev_q;
   logic [PIN_W-1:0]  chg_q;
   logic [PIN_W-1:0]  pin_diff;

   assign raw_in = {i_phy_status, i_pins};

   // --------------------------------------------------
   // Two-flop synchronizer plus previous-value stage
   // --------------------------------------------------
   // All inputs treated as asynchronous, bit by bit
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         meta_q <= '0;
         sync_q <= '0;
         prev_q <= '0;
      end else begin
         meta_q <= raw_in;
         sync_q <= meta_q;
         // Only the pins need edge history
         prev_q <= sync_q[PIN_W-1:0];
      end
   end

   // Any pin that moved since last cycle
   assign pin_diff = sync_q[PIN_W-1:0] ^ prev_q;

   // --------------------------------------------------
   // Sticky change flags
   // --------------------------------------------------
   // Clear has priority over a change seen in the same cycle
   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         chg_q <= '0;
      end else begin
         chg_q <= chg_q | pin_diff;
      end
   end

   // Status word assembly
   assign o_status.phy_status = sync_q[SYNC_W-1:PIN_W];
   assign o_status.zero       = '0;
   assign o_status.changed    = chg_q;
   assign o_status.pins       = sync_q[PIN_W-1:0];

endmodule

`default_nettype wire
